// ==== design/copy_pkg.sv ====
// shared widths, register map, buffer depth and state types; imported by every copy engine block
package copy_pkg;

    // byte addresses on both AXI4-Lite ports
    localparam int ADDR_W = 32;
    // one memory word per transfer
    localparam int DATA_W = 64;
    // a 64-bit word spans 8 bytes, so word addresses drop 3 low bits
    localparam int WORD_BYTE_BITS = 3;
    localparam int WORD_ADDR_W = ADDR_W - WORD_BYTE_BITS;

    // host register port
    localparam int CSR_DATA_W = 32;
    // 32-bit registers, byte index bits ignored on decode
    localparam int CSR_BYTE_BITS = 2;
    // length and written-word counters
    localparam int LEN_W = 16;

    // register map, byte offsets
    localparam logic [ADDR_W-1:0] REG_IN_ADDR = 'h00;
    localparam logic [ADDR_W-1:0] REG_IN_LEN = 'h04;
    localparam logic [ADDR_W-1:0] REG_OUT_ADDR = 'h08;
    // read only, words written by the last copy
    localparam logic [ADDR_W-1:0] REG_OUT_LEN = 'h0C;
    // write starts a copy, read returns done in bit 0
    localparam logic [ADDR_W-1:0] REG_CTRL = 'h10;

    // buffer between reader and writer, must be a power of two
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef logic [WORD_ADDR_W-1:0] t_word_addr;
    typedef logic [DATA_W-1:0] t_word;
    typedef logic [LEN_W-1:0] t_len;

    // controller only needs to know whether a copy is in progress
    typedef enum logic
    {
        CTRL_IDLE,
        CTRL_RUN
    } t_ctrl_state;

endpackage

// ==== design/copy_csr.sv ====
// AXI4-Lite register slave holding the copy configuration; host reads status through it
`timescale 1ns/1ps

module copy_csr (
    input  logic clk,
    input  logic reset,
    input  logic [copy_pkg::ADDR_W-1:0] s_awaddr,
    input  logic s_awvalid,
    output logic s_awready,
    input  logic [copy_pkg::CSR_DATA_W-1:0] s_wdata,
    input  logic s_wvalid,
    output logic s_wready,
    output logic s_bvalid,
    output logic [1:0] s_bresp,
    input  logic s_bready,
    input  logic [copy_pkg::ADDR_W-1:0] s_araddr,
    input  logic s_arvalid,
    output logic s_arready,
    output logic s_rvalid,
    output logic [1:0] s_rresp,
    output logic [copy_pkg::CSR_DATA_W-1:0] s_rdata,
    input  logic s_rready,
    input  logic done,
    input  copy_pkg::t_len out_len,
    output copy_pkg::t_word_addr in_addr,
    output copy_pkg::t_word_addr out_addr,
    output copy_pkg::t_len in_len,
    output logic start_pulse
);
    import copy_pkg::*;

    logic wr_ready;
    logic wr_fire;
    logic rd_fire;
    logic [ADDR_W-1:0] wr_offset;
    logic [ADDR_W-1:0] rd_offset;
    logic [CSR_DATA_W-1:0] rd_value;

    // ====================================================================
    // write channel
    // ====================================================================

    // address and data are accepted together in a single cycle
    assign s_awready = wr_ready;
    assign s_wready = wr_ready;
    assign wr_fire = wr_ready && s_awvalid && s_wvalid;
    assign s_bresp = AXI_RESP_OKAY;
    // byte lanes within a register are not decoded
    assign wr_offset = {s_awaddr[ADDR_W-1:CSR_BYTE_BITS], CSR_BYTE_BITS'(0)};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ready <= 1'b0;
            s_bvalid <= 1'b0;
            start_pulse <= 1'b0;
            in_addr <= '0;
            in_len <= '0;
            out_addr <= '0;
        end
        else
        begin
            // one-cycle ready once both valids are up and no response is pending
            wr_ready <= s_awvalid && s_wvalid && !s_bvalid && !wr_ready;
            // the written value of the control register does not matter
            start_pulse <= wr_fire && (wr_offset == REG_CTRL);

            if (wr_fire)
            begin
                s_bvalid <= 1'b1;
            end
            else if (s_bready)
            begin
                s_bvalid <= 1'b0;
            end

            // host gives byte addresses, engines work on word addresses
            if (wr_fire)
            begin
                case (wr_offset)
                    REG_IN_ADDR: in_addr <= s_wdata[ADDR_W-1:WORD_BYTE_BITS];
                    REG_IN_LEN: in_len <= s_wdata[LEN_W-1:0];
                    REG_OUT_ADDR: out_addr <= s_wdata[ADDR_W-1:WORD_BYTE_BITS];
                    // unknown offsets and read-only registers are acked and dropped
                    default: ;
                endcase
            end
        end
    end

    // ====================================================================
    // read channel
    // ====================================================================

    assign s_arready = s_arvalid && !s_rvalid;
    assign rd_fire = s_arvalid && s_arready;
    assign s_rresp = AXI_RESP_OKAY;
    assign rd_offset = {s_araddr[ADDR_W-1:CSR_BYTE_BITS], CSR_BYTE_BITS'(0)};

    always_comb
    begin
        case (rd_offset)
            REG_IN_ADDR: rd_value = {in_addr, WORD_BYTE_BITS'(0)};
            REG_IN_LEN: rd_value = CSR_DATA_W'(in_len);
            REG_OUT_ADDR: rd_value = {out_addr, WORD_BYTE_BITS'(0)};
            REG_OUT_LEN: rd_value = CSR_DATA_W'(out_len);
            REG_CTRL: rd_value = CSR_DATA_W'(done);
            default: rd_value = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s_rvalid <= 1'b0;
        end
        else if (rd_fire)
        begin
            s_rvalid <= 1'b1;
        end
        else if (s_rready)
        begin
            s_rvalid <= 1'b0;
        end
    end

    // read data held until the host takes it
    always_ff @(posedge clk)
    begin
        if (rd_fire)
        begin
            s_rdata <= rd_value;
        end
    end

endmodule

// ==== design/copy_ctrl.sv ====
// idle/run controller that launches both engines and records done and the written length
`timescale 1ns/1ps

module copy_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic start_pulse,
    input  logic finish,
    input  copy_pkg::t_len written,
    output logic go,
    output logic done,
    output copy_pkg::t_len out_len
);
    import copy_pkg::*;

    t_ctrl_state state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= CTRL_IDLE;
            go <= 1'b0;
            done <= 1'b0;
            out_len <= '0;
        end
        else
        begin
            // go is a single-cycle strobe
            go <= 1'b0;

            case (state)
                CTRL_IDLE:
                begin
                    // status of the previous copy is cleared on a new start
                    if (start_pulse)
                    begin
                        done <= 1'b0;
                        out_len <= '0;
                        go <= 1'b1;
                        state <= CTRL_RUN;
                    end
                end

                CTRL_RUN:
                begin
                    // start_pulse is ignored here, a running copy is never restarted
                    if (finish)
                    begin
                        out_len <= written;
                        done <= 1'b1;
                        state <= CTRL_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/copy_reader.sv ====
// AXI4-Lite read master that walks the source range and pushes each word into the buffer
`timescale 1ns/1ps

module copy_reader (
    input  logic clk,
    input  logic reset,
    input  logic go,
    input  copy_pkg::t_word_addr in_addr,
    input  copy_pkg::t_len in_len,
    output logic [copy_pkg::ADDR_W-1:0] m_araddr,
    output logic m_arvalid,
    input  logic m_arready,
    input  logic m_rvalid,
    output logic m_rready,
    input  copy_pkg::t_word m_rdata,
    input  logic fifo_full,
    output logic push,
    output copy_pkg::t_word push_data
);
    import copy_pkg::*;

    // next word address to fetch
    t_word_addr rd_addr;
    // words still to be fetched
    t_len remaining;
    // read address accepted, response outstanding
    logic rd_wait;

    // one read in flight; while arvalid is up nothing is pushed, so full cannot
    // rise and the request stays valid until accepted
    assign m_arvalid = (remaining != '0) && !rd_wait && !fifo_full;
    assign m_araddr = {rd_addr, WORD_BYTE_BITS'(0)};
    // a slot was free when the request went out, so the response always fits
    assign m_rready = rd_wait;

    // returned word goes straight into the buffer
    assign push = m_rvalid && rd_wait;
    assign push_data = m_rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remaining <= '0;
            rd_wait <= 1'b0;
        end
        else if (go)
        begin
            remaining <= in_len;
            rd_wait <= 1'b0;
        end
        else
        begin
            if (m_arvalid && m_arready)
            begin
                rd_wait <= 1'b1;
            end
            // response handshake ends the transaction
            if (push)
            begin
                rd_wait <= 1'b0;
                remaining <= remaining - 1'b1;
            end
        end
    end

    // address advances only after each response
    always_ff @(posedge clk)
    begin
        if (go)
        begin
            rd_addr <= in_addr;
        end
        else if (push)
        begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

endmodule

// ==== design/word_fifo.sv ====
// circular word buffer decoupling the read master from the write master
`timescale 1ns/1ps

module word_fifo (
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  copy_pkg::t_word push_data,
    input  logic pop,
    output copy_pkg::t_word pop_data,
    output logic full,
    output logic empty
);
    import copy_pkg::*;

    t_word mem [FIFO_DEPTH];
    // extra msb is the wrap bit
    logic [FIFO_PTR_W:0] wr_ptr;
    logic [FIFO_PTR_W:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    // same slot, opposite lap
    assign full = (wr_ptr[FIFO_PTR_W] != rd_ptr[FIFO_PTR_W]) &&
                  (wr_ptr[FIFO_PTR_W-1:0] == rd_ptr[FIFO_PTR_W-1:0]);
    // head word is visible before pop
    assign pop_data = mem[rd_ptr[FIFO_PTR_W-1:0]];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push && !full)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push && !full)
        begin
            mem[wr_ptr[FIFO_PTR_W-1:0]] <= push_data;
        end
    end

endmodule

// ==== design/copy_writer.sv ====
// AXI4-Lite write master that drains the buffer to the destination and counts acked writes
`timescale 1ns/1ps

module copy_writer (
    input  logic clk,
    input  logic reset,
    input  logic go,
    input  copy_pkg::t_word_addr out_addr,
    input  copy_pkg::t_len in_len,
    input  logic fifo_empty,
    input  copy_pkg::t_word pop_data,
    output logic pop,
    output logic [copy_pkg::ADDR_W-1:0] m_awaddr,
    output logic m_awvalid,
    input  logic m_awready,
    output copy_pkg::t_word m_wdata,
    output logic m_wvalid,
    input  logic m_wready,
    input  logic m_bvalid,
    output logic m_bready,
    output logic finish,
    output copy_pkg::t_len written
);
    import copy_pkg::*;

    t_word_addr wr_addr;
    // length captured at go, host may rewrite the register meanwhile
    t_len wr_len;
    t_word wr_data;
    // copy in progress
    logic run;
    // a word is in flight on the bus
    logic busy;
    logic aw_pend;
    logic w_pend;

    // next word only after the previous response
    assign pop = run && !busy && !fifo_empty && (written != wr_len);
    // with zero length this fires in the cycle after go
    assign finish = run && !busy && (written == wr_len);

    assign m_awvalid = aw_pend;
    assign m_wvalid = w_pend;
    assign m_awaddr = {wr_addr, WORD_BYTE_BITS'(0)};
    assign m_wdata = wr_data;
    // response accepted once address and data are both gone
    assign m_bready = busy && !aw_pend && !w_pend;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run <= 1'b0;
            busy <= 1'b0;
            aw_pend <= 1'b0;
            w_pend <= 1'b0;
            written <= '0;
        end
        else
        begin
            if (go)
            begin
                run <= 1'b1;
                written <= '0;
            end
            else if (finish)
            begin
                run <= 1'b0;
            end

            // popped word goes out on the next cycle
            if (pop)
            begin
                busy <= 1'b1;
                aw_pend <= 1'b1;
                w_pend <= 1'b1;
            end
            // address and data channels may be accepted in either order
            if (aw_pend && m_awready)
            begin
                aw_pend <= 1'b0;
            end
            if (w_pend && m_wready)
            begin
                w_pend <= 1'b0;
            end
            // only acknowledged writes are counted
            if (m_bready && m_bvalid)
            begin
                busy <= 1'b0;
                written <= written + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (go)
        begin
            wr_addr <= out_addr;
            wr_len <= in_len;
        end
        else if (m_bready && m_bvalid)
        begin
            wr_addr <= wr_addr + 1'b1;
        end

        if (pop)
        begin
            wr_data <= pop_data;
        end
    end

endmodule

// ==== design/copy_top.sv ====
// copy engine top level joining register slave, controller, reader, buffer and writer
`timescale 1ns/1ps

module copy_top (
    input  logic clk,
    input  logic reset,
    // host register port
    input  logic [copy_pkg::ADDR_W-1:0] s_awaddr,
    input  logic s_awvalid,
    output logic s_awready,
    input  logic [copy_pkg::CSR_DATA_W-1:0] s_wdata,
    input  logic s_wvalid,
    output logic s_wready,
    output logic s_bvalid,
    output logic [1:0] s_bresp,
    input  logic s_bready,
    input  logic [copy_pkg::ADDR_W-1:0] s_araddr,
    input  logic s_arvalid,
    output logic s_arready,
    output logic s_rvalid,
    output logic [1:0] s_rresp,
    output logic [copy_pkg::CSR_DATA_W-1:0] s_rdata,
    input  logic s_rready,
    // memory read side
    output logic [copy_pkg::ADDR_W-1:0] m_araddr,
    output logic m_arvalid,
    input  logic m_arready,
    input  logic m_rvalid,
    output logic m_rready,
    input  copy_pkg::t_word m_rdata,
    // memory write side
    output logic [copy_pkg::ADDR_W-1:0] m_awaddr,
    output logic m_awvalid,
    input  logic m_awready,
    output copy_pkg::t_word m_wdata,
    output logic m_wvalid,
    input  logic m_wready,
    input  logic m_bvalid,
    output logic m_bready
);
    import copy_pkg::*;

    // configuration and status
    t_word_addr in_addr;
    t_word_addr out_addr;
    t_len in_len;
    t_len out_len;
    t_len written;
    logic start_pulse;
    logic go;
    logic done;
    logic finish;

    // buffer traffic
    logic push;
    t_word push_data;
    logic pop;
    t_word pop_data;
    logic fifo_full;
    logic fifo_empty;

    // ====================================================================
    // control path
    // ====================================================================

    copy_csr csr_i (
        .clk(clk),
        .reset(reset),
        .s_awaddr(s_awaddr),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .s_wdata(s_wdata),
        .s_wvalid(s_wvalid),
        .s_wready(s_wready),
        .s_bvalid(s_bvalid),
        .s_bresp(s_bresp),
        .s_bready(s_bready),
        .s_araddr(s_araddr),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .s_rvalid(s_rvalid),
        .s_rresp(s_rresp),
        .s_rdata(s_rdata),
        .s_rready(s_rready),
        .done(done),
        .out_len(out_len),
        .in_addr(in_addr),
        .out_addr(out_addr),
        .in_len(in_len),
        .start_pulse(start_pulse)
    );

    copy_ctrl ctrl_i (
        .clk(clk),
        .reset(reset),
        .start_pulse(start_pulse),
        .finish(finish),
        .written(written),
        .go(go),
        .done(done),
        .out_len(out_len)
    );

    // ====================================================================
    // data path, reads overlap writes through the buffer
    // ====================================================================

    copy_reader reader_i (
        .clk(clk),
        .reset(reset),
        .go(go),
        .in_addr(in_addr),
        .in_len(in_len),
        .m_araddr(m_araddr),
        .m_arvalid(m_arvalid),
        .m_arready(m_arready),
        .m_rvalid(m_rvalid),
        .m_rready(m_rready),
        .m_rdata(m_rdata),
        .fifo_full(fifo_full),
        .push(push),
        .push_data(push_data)
    );

    word_fifo fifo_i (
        .clk(clk),
        .reset(reset),
        .push(push),
        .push_data(push_data),
        .pop(pop),
        .pop_data(pop_data),
        .full(fifo_full),
        .empty(fifo_empty)
    );

    copy_writer writer_i (
        .clk(clk),
        .reset(reset),
        .go(go),
        .out_addr(out_addr),
        .in_len(in_len),
        .fifo_empty(fifo_empty),
        .pop_data(pop_data),
        .pop(pop),
        .m_awaddr(m_awaddr),
        .m_awvalid(m_awvalid),
        .m_awready(m_awready),
        .m_wdata(m_wdata),
        .m_wvalid(m_wvalid),
        .m_wready(m_wready),
        .m_bvalid(m_bvalid),
        .m_bready(m_bready),
        .finish(finish),
        .written(written)
    );

endmodule

// ==== tests/copy_tb.sv ====
// testbench for copy_top; runs the copy tests listed in tests/copy_stimulus.txt against a memory model
`timescale 1ns/1ps

module copy_tb;
    import copy_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    localparam int CLK_HALF = 50;
    localparam int RESET_CYCLES = 10;
    localparam string STIM_FILE = "tests/copy_stimulus.txt";

    logic clk;
    logic reset;

    // host register port
    logic [ADDR_W-1:0] s_awaddr;
    logic s_awvalid;
    logic s_awready;
    logic [CSR_DATA_W-1:0] s_wdata;
    logic s_wvalid;
    logic s_wready;
    logic s_bvalid;
    logic [1:0] s_bresp;
    logic s_bready;
    logic [ADDR_W-1:0] s_araddr;
    logic s_arvalid;
    logic s_arready;
    logic s_rvalid;
    logic [1:0] s_rresp;
    logic [CSR_DATA_W-1:0] s_rdata;
    logic s_rready;

    // memory side
    logic [ADDR_W-1:0] m_araddr;
    logic m_arvalid;
    logic m_arready;
    logic m_rvalid;
    logic m_rready;
    t_word m_rdata;
    logic [ADDR_W-1:0] m_awaddr;
    logic m_awvalid;
    logic m_awready;
    t_word m_wdata;
    logic m_wvalid;
    logic m_wready;
    logic m_bvalid;
    logic m_bready;

    // memory model and the expected image of it
    t_word mem [MEM_WORDS];
    t_word exp_mem [MEM_WORDS];

    // one entry per stimulus line
    string test_name [$];
    logic [ADDR_W-1:0] test_src [$];
    int test_len [$];
    logic [ADDR_W-1:0] test_dst [$];
    int test_exp_len [$];
    bit test_restart [$];

    // name of the test whose register accesses are running
    string cur_test;

    int cycles;
    int cycle_limit;

    copy_top dut_i (
        .clk(clk),
        .reset(reset),
        .s_awaddr(s_awaddr),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .s_wdata(s_wdata),
        .s_wvalid(s_wvalid),
        .s_wready(s_wready),
        .s_bvalid(s_bvalid),
        .s_bresp(s_bresp),
        .s_bready(s_bready),
        .s_araddr(s_araddr),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .s_rvalid(s_rvalid),
        .s_rresp(s_rresp),
        .s_rdata(s_rdata),
        .s_rready(s_rready),
        .m_araddr(m_araddr),
        .m_arvalid(m_arvalid),
        .m_arready(m_arready),
        .m_rvalid(m_rvalid),
        .m_rready(m_rready),
        .m_rdata(m_rdata),
        .m_awaddr(m_awaddr),
        .m_awvalid(m_awvalid),
        .m_awready(m_awready),
        .m_wdata(m_wdata),
        .m_wvalid(m_wvalid),
        .m_wready(m_wready),
        .m_bvalid(m_bvalid),
        .m_bready(m_bready)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // byte address to model index, the model covers 8 KB
    function automatic int word_index(input logic [ADDR_W-1:0] addr);
        return int'(addr[WORD_BYTE_BITS +: MEM_IDX_W]);
    endfunction

    task automatic word_check(input string what, input t_word expected, input t_word actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic len_check(input string what, input t_len expected, input t_len actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %0d, actual %0d", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic done_check(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %b, actual %b", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic addr_check(input string what, input logic [CSR_DATA_W-1:0] expected,
                              input logic [CSR_DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic ready_check(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %b, actual %b", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic resp_check(input string what, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %b, actual %b", what, expected, actual);
            abort_run();
        end
    endtask

    // address and data offered together, then the response is taken
    task automatic write_csr(input logic [ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] data);
        @(negedge clk);
        s_awaddr = addr;
        s_awvalid = 1'b1;
        s_wdata = data;
        s_wvalid = 1'b1;
        s_bready = 1'b1;
        @(negedge clk);
        while (!s_awready) @(negedge clk);
        // both channels are accepted in the same cycle
        ready_check({cur_test, " wready"}, 1'b1, s_wready);
        // handshake on the coming rising edge
        @(negedge clk);
        s_awvalid = 1'b0;
        s_wvalid = 1'b0;
        while (!s_bvalid) @(negedge clk);
        resp_check({cur_test, " bresp"}, AXI_RESP_OKAY, s_bresp);
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    // slave takes arvalid at once unless a response is pending
    task automatic read_csr(input logic [ADDR_W-1:0] addr, output logic [CSR_DATA_W-1:0] data);
        @(negedge clk);
        s_araddr = addr;
        s_arvalid = 1'b1;
        s_rready = 1'b1;
        // arready is combinational and is looked at just before the edge that takes it
        @(posedge clk);
        ready_check({cur_test, " arready"}, 1'b1, s_arready);
        @(negedge clk);
        while (!s_rvalid) @(negedge clk);
        resp_check({cur_test, " rresp"}, AXI_RESP_OKAY, s_rresp);
        data = s_rdata;
        s_arvalid = 1'b0;
        @(negedge clk);
        s_rready = 0;
    endtask

    task automatic load_tests(output int total);
        int fd;
        int n;
        string line;
        string name;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        int len;
        int exp_len;
        int restart;
        total = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open stimulus file %s", STIM_FILE);
            abort_run();
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            // comment lines start with #
            if (n > 0 && line.len() > 0 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%s %h %d %h %d %d", name, src, len, dst, exp_len, restart);
                if (n == 6)
                begin
                    test_name.push_back(name);
                    test_src.push_back(src);
                    test_len.push_back(len);
                    test_dst.push_back(dst);
                    test_exp_len.push_back(exp_len);
                    test_restart.push_back(restart != 0);
                    total = total + len;
                end
                else if (n > 0)
                begin
                    $display("malformed stimulus line: %s", line);
                    abort_run();
                end
            end
        end
        $fclose(fd);
        if (test_name.size() == 0)
        begin
            $display("stimulus file holds no tests");
            abort_run();
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] = {$urandom, $urandom};
            exp_mem[i] = mem[i];
        end
    endtask

    // ======================================================================
    // memory model, random 0..3 cycle delays per channel
    // ======================================================================

    initial
    begin : read_model
        int delay;
        logic [ADDR_W-1:0] addr;
        m_arready = 1'b0;
        m_rvalid = 1'b0;
        m_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (!reset && m_arvalid)
            begin
                delay = $urandom_range(0, 3);
                repeat (delay) @(negedge clk);
                m_arready = 1'b1;
                addr = m_araddr;
                @(negedge clk);
                m_arready = 1'b0;
                delay = $urandom_range(0, 3);
                repeat (delay) @(negedge clk);
                m_rvalid = 1'b1;
                m_rdata = mem[word_index(addr)];
                while (!m_rready) @(negedge clk);
                @(negedge clk);
                m_rvalid = 1'b0;
            end
        end
    end

    initial
    begin : write_model
        int aw_delay;
        int w_delay;
        int b_delay;
        bit aw_done;
        bit w_done;
        logic [ADDR_W-1:0] addr;
        t_word data;
        m_awready = 1'b0;
        m_wready = 1'b0;
        m_bvalid = 1'b0;
        forever
        begin
            @(negedge clk);
            if (!reset && m_awvalid && m_wvalid)
            begin
                aw_delay = $urandom_range(0, 3);
                w_delay = $urandom_range(0, 3);
                aw_done = 1'b0;
                w_done = 1'b0;
                // address and data channels count down on their own
                while (!(aw_done && w_done))
                begin
                    m_awready = !aw_done && (aw_delay == 0);
                    m_wready = !w_done && (w_delay == 0);
                    if (m_awready)
                        addr = m_awaddr;
                    if (m_wready)
                        data = m_wdata;
                    @(negedge clk);
                    if (m_awready)
                        aw_done = 1'b1;
                    else if (!aw_done)
                        aw_delay = aw_delay - 1;
                    if (m_wready)
                        w_done = 1'b1;
                    else if (!w_done)
                        w_delay = w_delay - 1;
                end
                m_awready = 1'b0;
                m_wready = 1'b0;
                mem[word_index(addr)] = data;
                b_delay = $urandom_range(0, 3);
                repeat (b_delay) @(negedge clk);
                m_bvalid = 1'b1;
                while (!m_bready) @(negedge clk);
                @(negedge clk);
                m_bvalid = 1'b0;
            end
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout, no result after %0d cycles", cycles);
            abort_run();
        end
    end

    task automatic run_test(input int idx);
        string name;
        logic [CSR_DATA_W-1:0] rd;
        int src_w;
        int dst_w;
        bit done_seen;
        name = test_name[idx];
        cur_test = name;
        write_csr(REG_IN_ADDR, test_src[idx]);
        write_csr(REG_IN_LEN, CSR_DATA_W'(test_len[idx]));
        write_csr(REG_OUT_ADDR, test_dst[idx]);

        // byte addresses come back with the word offset cleared
        read_csr(REG_IN_ADDR, rd);
        addr_check({name, " in_addr"}, test_src[idx] & ~32'h7, rd);
        read_csr(REG_IN_LEN, rd);
        len_check({name, " in_len"}, t_len'(test_len[idx]), rd[LEN_W-1:0]);
        read_csr(REG_OUT_ADDR, rd);
        addr_check({name, " out_addr"}, test_dst[idx] & ~32'h7, rd);

        // ranges never overlap, so an in-place update is exact
        src_w = word_index(test_src[idx]);
        dst_w = word_index(test_dst[idx]);
        for (int k = 0; k < test_len[idx]; k++)
        begin
            exp_mem[(dst_w + k) % MEM_WORDS] = exp_mem[(src_w + k) % MEM_WORDS];
        end

        write_csr(REG_CTRL, 32'h1);
        // second start lands while the first copy runs
        if (test_restart[idx])
            write_csr(REG_CTRL, 32'h1);

        done_seen = 1'b0;
        while (!done_seen)
        begin
            read_csr(REG_CTRL, rd);
            done_seen = rd[0];
        end
        // done is sticky until the next start
        read_csr(REG_CTRL, rd);
        done_check({name, " done held"}, 1'b1, rd[0]);
        read_csr(REG_OUT_LEN, rd);
        len_check({name, " out_len"}, t_len'(test_exp_len[idx]), rd[LEN_W-1:0]);

        for (int i = 0; i < MEM_WORDS; i++)
        begin
            word_check($sformatf("%s word %0d", name, i), exp_mem[i], mem[i]);
        end
        $display("%s: %0d words compared", name, test_len[idx]);
    endtask

    initial
    begin : main_seq
        int total_len;
        int unsigned seed_val;
        logic [CSR_DATA_W-1:0] rd;
        seed_val = $urandom(32'h908f561c);
        cycles = 0;
        cycle_limit = 200;
        reset = 1'b1;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;

        load_tests(total_len);
        cycle_limit = 200 + 40 * total_len;
        fill_memory();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // status registers come out of reset cleared
        cur_test = "after reset";
        read_csr(REG_CTRL, rd);
        done_check("after reset done", 1'b0, rd[0]);
        read_csr(REG_OUT_LEN, rd);
        len_check("after reset out_len", '0, rd[LEN_W-1:0]);

        foreach (test_name[i])
        begin
            run_test(i);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== tests/copy_stimulus.txt ====
# name  src_byte_addr(hex)  length(dec)  dst_byte_addr(hex)  expected_out_len(dec)  restart(0/1)
# ranges stay inside the 8 KB memory model and never overlap within a test
single      0000  1   1000  1   0
short       0108  3   1100  3   0
unaligned   0205  4   1203  4   0
fifo_wrap   0300  7   1300  7   0
long        0400  24  1400  24  0
zero        0500  0   1500  0   0
restart     0600  10  1600  10  1
chained     1400  12  0800  12  0
top_end     1fb8  9   0a00  9   0

// ==== project.f ====
design/copy_pkg.sv
design/copy_csr.sv
design/copy_ctrl.sv
design/copy_reader.sv
design/word_fifo.sv
design/copy_writer.sv
design/copy_top.sv
tests/copy_tb.sv
